/* hw/imul_pkg.sv */
// Shared widths and control state encoding for the iterative multiplier
// Every RTL block takes these by wildcard import

package imul_pkg;

  // --------------------
  // Widths
  // --------------------

  // Operand and result width
  localparam int DATA_W = 32;

  // Input message carries a in the upper half and b in the lower half
  localparam int MSG_W = 2 * DATA_W;

  // Shift amounts and bit counts, wide enough to hold DATA_W itself
  localparam int SHAMT_W = 6;

  // --------------------
  // Control states
  // --------------------

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0, // Waiting for operands
    ST_CALC = 2'd1, // One add/skip step per cycle
    ST_DONE = 2'd2  // Result held until the output transfer
  } imul_state_e;

endpackage

/* hw/imul_ctrl.sv */
// Multiplier controller
// Runs the input and output stream handshakes and issues load and step

module imul_ctrl import imul_pkg::*; (
  input  logic clk,
  input  logic reset,

  // Input stream handshake
  input  logic in_val,
  output logic in_rdy,

  // Output stream handshake
  output logic out_val,
  input  logic out_rdy,

  // Status from the b scanner
  input  logic all_consumed,

  // Datapath commands
  output logic load,
  output logic step
);

  // --------------------
  // State register
  // --------------------

  imul_state_e state_q;
  imul_state_e state_d;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------
  // Transitions
  // --------------------

  logic in_go;
  logic out_go;

  assign in_go  = in_val && in_rdy;   // Operands accepted this edge
  assign out_go = out_val && out_rdy; // Result taken this edge

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (in_go) begin
          state_d = ST_CALC;
        end
      end
      ST_CALC: begin
        // Last step is the one that consumes the final bit positions
        if (all_consumed) begin
          state_d = ST_DONE;
        end
      end
      ST_DONE: begin
        if (out_go) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  // --------------------
  // Outputs
  // --------------------

  // Handshake flags follow the state alone
  assign in_rdy  = (state_q == ST_IDLE);
  assign out_val = (state_q == ST_DONE);

  // Load lands on the accept edge, so it mirrors in_val while idle
  assign load = in_val && (state_q == ST_IDLE);

  // Every calc cycle is a step
  assign step = (state_q == ST_CALC);

endmodule

/* hw/imul_b_scanner.sv */
// Multiplier operand scanner
// Holds b, picks each step's shift amount and counts consumed bit positions

module imul_b_scanner import imul_pkg::*; (
  input  logic               clk,
  input  logic               reset,

  // Commands from the controller
  input  logic               load,
  input  logic               step,

  // Operand b from the input message
  input  logic [DATA_W-1:0]  b_in,

  // Step results
  output logic [SHAMT_W-1:0] shamt,        // Shift for b and a this step
  output logic               b_lsb,        // Add a into the result this step
  output logic               all_consumed  // This step finishes the product
);

  // --------------------
  // Registers
  // --------------------

  logic [DATA_W-1:0]  b_q;
  logic [SHAMT_W-1:0] count_q; // Bit positions of b already consumed

  // --------------------
  // Shift amount
  // --------------------

  logic [SHAMT_W-1:0] remaining;
  logic [SHAMT_W-1:0] tz_count;
  logic [SHAMT_W-1:0] count_next;

  // Positions of b not yet consumed
  assign remaining = SHAMT_W'(DATA_W) - count_q;

  // Trailing zero count of b
  // Scanned from the top so the lowest set bit is the last one written
  always_comb begin
    tz_count = SHAMT_W'(DATA_W);
    for (int i = DATA_W - 1; i >= 0; i--) begin
      if (b_q[i]) begin
        tz_count = SHAMT_W'(i);
      end
    end
  end

  always_comb begin
    if (b_q[0]) begin
      // Add-and-shift step, one position
      shamt = SHAMT_W'(1);
    end else if (b_q == '0) begin
      // Nothing left to add, finish in one step
      shamt = remaining;
    end else if (tz_count > remaining) begin
      shamt = remaining; // Never run past the last position
    end else begin
      shamt = tz_count;  // Skip the whole zero run
    end
  end

  assign b_lsb = b_q[0];

  // --------------------
  // Consumed-bit count
  // --------------------

  // Shift amount is capped by remaining, so this never exceeds DATA_W
  assign count_next   = count_q + shamt;
  assign all_consumed = (count_next == SHAMT_W'(DATA_W));

  always_ff @(posedge clk) begin
    if (reset) begin
      count_q <= '0;
    end else if (load) begin
      count_q <= '0;         // Fresh operand, nothing consumed yet
    end else if (step) begin
      count_q <= count_next;
    end
  end

  // --------------------
  // b register
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      b_q <= '0;
    end else if (load) begin
      b_q <= b_in;
    end else if (step) begin
      b_q <= b_q >> shamt;   // Drop the bits this step consumed
    end
  end

endmodule

/* hw/imul_a_shifter.sv */
// Multiplicand register
// Shifts a left by the scanner's amount on every step

module imul_a_shifter import imul_pkg::*; (
  input  logic               clk,
  input  logic               reset,

  // Commands from the controller
  input  logic               load,
  input  logic               step,

  // Operand a and the step's shift
  input  logic [DATA_W-1:0]  a_in,
  input  logic [SHAMT_W-1:0] shamt,

  // Multiplicand weighted for the current bit of b
  output logic [DATA_W-1:0]  a_value
);

  logic [DATA_W-1:0] a_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      a_q <= '0;
    end else if (load) begin
      a_q <= a_in;
    end else if (step) begin
      // Bits shifted past the top drop out, giving the truncated product
      a_q <= a_q << shamt;
    end
  end

  // Pre-shift value, the one the accumulator adds this step
  assign a_value = a_q;

endmodule

/* hw/imul_accum.sv */
// Result accumulator
// Adds the multiplicand in on steps where the scanned bit of b is one

module imul_accum import imul_pkg::*; (
  input  logic              clk,
  input  logic              reset,

  // Commands from the controller
  input  logic              load,
  input  logic              step,

  // Step inputs from the scanner and the shifter
  input  logic              b_lsb,
  input  logic [DATA_W-1:0] a_value,

  // Partial product, final once the calc ends
  output logic [DATA_W-1:0] result
);

  logic [DATA_W-1:0] result_q;
  logic [DATA_W-1:0] sum;

  assign sum = result_q + a_value; // Carry out of the top is dropped

  always_ff @(posedge clk) begin
    if (reset) begin
      result_q <= '0;
    end else if (load) begin
      result_q <= '0;                // New product starts from zero
    end else if (step && b_lsb) begin
      result_q <= sum;
    end
  end

  // No writes outside load and step, so the value holds through done
  assign result = result_q;

endmodule

/* hw/imul_top.sv */
// Variable-latency iterative multiplier
// Low half of a * b over val/rdy streams, one item in flight

module imul_top import imul_pkg::*; (
  input  logic              clk,
  input  logic              reset,

  // Input stream, a in the upper half and b in the lower half
  input  logic              in_val,
  output logic              in_rdy,
  input  logic [MSG_W-1:0]  in_msg,

  // Output stream
  output logic              out_val,
  input  logic              out_rdy,
  output logic [DATA_W-1:0] out_msg
);

  // --------------------
  // Operand split
  // --------------------

  logic [DATA_W-1:0] a_in;
  logic [DATA_W-1:0] b_in;

  assign a_in = in_msg[MSG_W-1:DATA_W];
  assign b_in = in_msg[DATA_W-1:0];

  // --------------------
  // Internal wiring
  // --------------------

  logic               load;
  logic               step;
  logic [SHAMT_W-1:0] shamt;
  logic               b_lsb;
  logic               all_consumed;
  logic [DATA_W-1:0]  a_value;

  imul_ctrl u_ctrl (
    .clk          (clk),
    .reset        (reset),
    .in_val       (in_val),
    .in_rdy       (in_rdy),
    .out_val      (out_val),
    .out_rdy      (out_rdy),
    .all_consumed (all_consumed),
    .load         (load),
    .step         (step)
  );

  // Scanner and shifter advance side by side on each step
  imul_b_scanner u_b_scanner (
    .clk          (clk),
    .reset        (reset),
    .load         (load),
    .step         (step),
    .b_in         (b_in),
    .shamt        (shamt),
    .b_lsb        (b_lsb),
    .all_consumed (all_consumed)
  );

  imul_a_shifter u_a_shifter (
    .clk          (clk),
    .reset        (reset),
    .load         (load),
    .step         (step),
    .a_in         (a_in),
    .shamt        (shamt),
    .a_value      (a_value)
  );

  imul_accum u_accum (
    .clk          (clk),
    .reset        (reset),
    .load         (load),
    .step         (step),
    .b_lsb        (b_lsb),
    .a_value      (a_value),
    .result       (out_msg)  // Result register feeds the output stream
  );

endmodule

/* tests/tb_clock.sv */
// Testbench clock source
// Free-running clock, period 8

module tb_clock (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always begin
    #4 clk = ~clk; // Half period
  end

endmodule

/* tests/imul_checker.sv */
// Stream protocol checks for the multiplier
// Bound into imul_top, counts its own assertion failures

module imul_checker import imul_pkg::*; (
  input logic              clk,
  input logic              reset,
  input logic              in_rdy,
  input logic              out_val,
  input logic              out_rdy,
  input logic [DATA_W-1:0] out_msg
);

  int unsigned assert_failures = 0; // Read by the testbench summary

  // Stalled result must hold until taken
  a_out_hold: assert property (@(posedge clk) disable iff (reset)
    (out_val && !out_rdy) |=> (out_val && $stable(out_msg)))
    else begin
      assert_failures++;
      $error("out_msg or out_val changed while the output was stalled");
    end

  // Only one item in flight
  a_one_item: assert property (@(posedge clk) disable iff (reset)
    !(in_rdy && out_val))
    else begin
      assert_failures++;
      $error("in_rdy and out_val high in the same cycle");
    end

  a_reset_idle: assert property (@(posedge clk) reset |=> !out_val)
    else begin
      assert_failures++;
      $error("out_val high in the cycle after reset");
    end

endmodule

bind imul_top imul_checker u_checker (
  .clk     (clk),
  .reset   (reset),
  .in_rdy  (in_rdy),
  .out_val (out_val),
  .out_rdy (out_rdy),
  .out_msg (out_msg)
);

/* tests/imul_tb.sv */
// Directed testbench for the iterative multiplier
// Products, latency, back-pressure and the busy handshake

module imul_tb import imul_pkg::*; ();

  localparam int NUM_TXN     = 79;                // Corners, random, zero, stall, busy
  localparam int CYCLE_LIMIT = 40 * NUM_TXN + 100;

  logic              clk;
  logic              reset;
  logic              in_val;
  logic              in_rdy;
  logic [MSG_W-1:0]  in_msg;
  logic              out_val;
  logic              out_rdy;
  logic [DATA_W-1:0] out_msg;

  int          error_count = 0;
  int          check_count = 0;
  int          cycle_count = 0;
  logic [31:0] rng_state   = 32'h8617;

  tb_clock u_clock (
    .clk (clk)
  );

  imul_top dut (
    .clk     (clk),
    .reset   (reset),
    .in_val  (in_val),
    .in_rdy  (in_rdy),
    .in_msg  (in_msg),
    .out_val (out_val),
    .out_rdy (out_rdy),
    .out_msg (out_msg)
  );

  // --------------------
  // Helpers
  // --------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Called and returns just after a clock edge
  task automatic send_operands(input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
    while (!in_rdy) begin
      @(posedge clk);
      #1;
    end
    in_val = 1'b1;
    in_msg = {a, b};
    @(posedge clk); // Accept edge
    #1;
    in_val = 1'b0;
  endtask

  // Edges from the accept edge to the first edge that sees out_val high
  task automatic wait_result(output int latency);
    latency = 1;
    while (!out_val) begin
      @(posedge clk);
      #1;
      latency++;
    end
  endtask

  task automatic take_result();
    out_rdy = 1'b1;
    @(posedge clk); // Output transfer
    #1;
    out_rdy = 1'b0;
  endtask

  task automatic run_product(input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
    logic [DATA_W-1:0] expected;
    int                latency;
    expected = a * b; // Low half only
    send_operands(a, b);
    wait_result(latency);
    check_count++;
    if (out_msg !== expected) begin
      error_count++;
      $display("ERR out_msg: a=%h b=%h got %h expected %h", a, b, out_msg, expected);
    end
    check_count++;
    if (latency < 2 || latency > 33) begin
      error_count++;
      $display("Latency of %0d cycles is outside 2 to 33 for a=%h b=%h", latency, a, b);
    end
    take_result();
  endtask

  // --------------------
  // Tests
  // --------------------

  task automatic test_corner_products();
    run_product(32'h0000_0000, 32'h0000_0000);
    run_product(32'h0000_0000, 32'hffff_ffff);
    run_product(32'h0000_0001, 32'h0000_0001);
    run_product(32'h0000_0001, 32'hffff_ffff);
    run_product(32'hffff_ffff, 32'h0000_0001);
    run_product(32'hffff_ffff, 32'hffff_ffff);
    run_product(32'h8000_0000, 32'h0000_0001);
    run_product(32'h0000_0001, 32'h8000_0000);
    run_product(32'h8000_0000, 32'h8000_0000);
    run_product(32'haaaa_aaaa, 32'h5555_5555);
    run_product(32'h5555_5555, 32'haaaa_aaaa);
    run_product(32'h1234_5678, 32'h9abc_def0);
    run_product(32'h0001_0000, 32'h0001_0000); // Product lands just past the top
    run_product(32'h0000_ffff, 32'h0000_ffff);
    run_product(32'h0000_0003, 32'h4000_0000);
  endtask

  task automatic test_random_products();
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    for (int i = 0; i < 60; i++) begin
      rng_state = xorshift32(rng_state);
      a = rng_state;
      rng_state = xorshift32(rng_state);
      b = rng_state;
      run_product(a, b);
    end
  endtask

  task automatic test_zero_multiplier(input logic [DATA_W-1:0] a);
    int latency;
    send_operands(a, 32'h0);
    wait_result(latency);
    check_count++;
    if (latency != 2) begin
      error_count++;
      $display("ERR latency: a=%h b=0 got %h expected %h", a, latency, 2);
    end
    check_count++;
    if (out_msg !== 32'h0) begin
      error_count++;
      $display("ERR out_msg: a=%h b=0 got %h expected %h", a, out_msg, 32'h0);
    end
    take_result();
  endtask

  task automatic test_back_pressure();
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] held;
    int                latency;
    a = 32'hdead_beef;
    b = 32'h0000_0f03;
    send_operands(a, b);
    wait_result(latency);
    // Two adds, one skip of six zeros, four adds, then the zero finish
    check_count++;
    if (latency != 9) begin
      error_count++;
      $display("ERR latency: a=%h b=%h got %h expected %h", a, b, latency, 9);
    end
    held = out_msg;
    repeat (6) begin
      @(posedge clk);
      #1;
      check_count++;
      if (out_val !== 1'b1 || out_msg !== held || in_rdy !== 1'b0) begin
        error_count++;
        $display("ERR out_val/out_msg/in_rdy under stall: got %h/%h/%h expected %h/%h/%h",
                 out_val, out_msg, in_rdy, 1'b1, held, 1'b0);
      end
    end
    check_count++;
    if (held !== a * b) begin
      error_count++;
      $display("ERR out_msg: a=%h b=%h got %h expected %h", a, b, held, a * b);
    end
    take_result();
    check_count++;
    if (in_rdy !== 1'b1 || out_val !== 1'b0) begin
      error_count++;
      $display("ERR in_rdy/out_val after transfer: got %h/%h expected %h/%h",
               in_rdy, out_val, 1'b1, 1'b0);
    end
  endtask

  task automatic test_busy_handshake();
    logic [DATA_W-1:0] a1;
    logic [DATA_W-1:0] b1;
    a1 = 32'h0000_1234;
    b1 = 32'hffff_ffff; // Longest calculation
    send_operands(a1, b1);
    in_val = 1'b1;      // Second item offered while busy
    in_msg = {32'h0000_0007, 32'h0000_0009};
    while (!out_val) begin
      check_count++;
      if (in_rdy !== 1'b0) begin
        error_count++;
        $display("ERR in_rdy while busy: got %h expected %h", in_rdy, 1'b0);
      end
      @(posedge clk);
      #1;
    end
    in_val = 1'b0;
    check_count++;
    if (out_msg !== a1 * b1) begin
      error_count++;
      $display("ERR out_msg: a=%h b=%h got %h expected %h", a1, b1, out_msg, a1 * b1);
    end
    take_result();
    check_count++;
    if (in_rdy !== 1'b1) begin
      error_count++;
      $display("ERR in_rdy after transfer: got %h expected %h", in_rdy, 1'b1);
    end
  endtask

  // --------------------
  // Run control
  // --------------------

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: no finish within %0d cycles", CYCLE_LIMIT);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    int assert_failures;
    in_val  = 1'b0;
    in_msg  = '0;
    out_rdy = 1'b0;
    reset   = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    check_count++;
    if (in_rdy !== 1'b1 || out_val !== 1'b0) begin
      error_count++;
      $display("ERR in_rdy/out_val after reset: got %h/%h expected %h/%h",
               in_rdy, out_val, 1'b1, 1'b0);
    end

    test_corner_products();
    test_random_products();
    test_zero_multiplier(32'hffff_ffff);
    test_zero_multiplier(32'h0000_0000);
    test_back_pressure();
    test_busy_handshake();

    assert_failures = dut.u_checker.assert_failures;
    $display("Summary: %0d checks, %0d errors, %0d assertion failures",
             check_count, error_count, assert_failures);
    if (error_count == 0 && assert_failures == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* verilog.f */
hw/imul_pkg.sv
hw/imul_ctrl.sv
hw/imul_b_scanner.sv
hw/imul_a_shifter.sv
hw/imul_accum.sv
hw/imul_top.sv
tests/tb_clock.sv
tests/imul_checker.sv
tests/imul_tb.sv
